//--- Makefile
# Verilator build and run for the slurm16 core testbench

VERILATOR ?= verilator
TOP       ?= tb_slurm_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ALL TESTS PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
slurm_pkg.sv
slurm_alu.sv
slurm_regfile.sv
slurm_fetch.sv
slurm_insn_queue.sv
slurm_execute.sv
slurm_core.sv
tb_slurm_core.sv

//--- slurm_alu.sv
/*
 * slurm16 ALU
 * Mov, add, sub and bitwise ops with zero, sign and carry flags
 */
`timescale 1ns/1ns
`default_nettype none

module slurm_alu import slurm_pkg::*; (
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   result,
	output logic    z,
	output logic    s,
	output logic    c
);

	logic [16:0] sum;	// Extra bit holds carry or borrow

	always_comb begin
		sum    = '0;
		result = b;
		c      = 1'b0;
		case (op)
			ALU_ADD: begin
				sum    = {1'b0, a} + {1'b0, b};
				result = sum[15:0];
				c      = sum[16];
			end
			ALU_SUB: begin
				sum    = {1'b0, a} - {1'b0, b};
				result = sum[15:0];
				c      = sum[16];	// Borrow
			end
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			default: result = b;	// Mov and unused codes
		endcase
	end

	assign z = (result == '0);
	assign s = result[15];

endmodule

`default_nettype wire

//--- slurm_core.sv
/*
 * slurm16 core top level
 * Fetch, instruction queue and execute, with instruction memory
 * and register write-back at the ports
 */
`timescale 1ns/1ns
`default_nettype none

module slurm_core import slurm_pkg::*; (
	input  wire      CLK,
	input  wire      RSTb,

	output logic     mem_valid,
	output word_t    mem_addr,
	input  wire      mem_ready,
	input  word_t    mem_rdata,

	output logic     wb_en,
	output reg_idx_t wb_addr,
	output word_t    wb_data
);

	logic  not_full, push, pop;
	logic  head_valid;
	logic  redirect;
	word_t push_word, head_word, redirect_pc;

	slurm_fetch i_fetch (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.mem_valid   (mem_valid),
		.mem_addr    (mem_addr),
		.mem_ready   (mem_ready),
		.mem_rdata   (mem_rdata),
		.not_full    (not_full),
		.push        (push),
		.push_word   (push_word),
		.redirect    (redirect),
		.redirect_pc (redirect_pc)
	);

	slurm_insn_queue i_queue (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.push       (push),
		.push_word  (push_word),
		.pop        (pop),
		.flush      (redirect),	// Taken branch drops queued words
		.not_full   (not_full),
		.head_valid (head_valid),
		.head_word  (head_word)
	);

	slurm_execute i_execute (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.head_valid  (head_valid),
		.head_word   (head_word),
		.pop         (pop),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.wb_en       (wb_en),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

endmodule

`default_nettype wire

//--- slurm_execute.sv
/*
 * slurm16 execute stage
 * Decode of the queue head, immediate prefix, register and flag interlock,
 * branch resolution, and one execute register feeding register write-back
 */
`timescale 1ns/1ns
`default_nettype none

module slurm_execute import slurm_pkg::*; (
	input  wire      CLK,
	input  wire      RSTb,

	// Instruction queue head
	input  wire      head_valid,
	input  word_t    head_word,
	output logic     pop,

	// Branch back to fetch
	output logic     redirect,
	output word_t    redirect_pc,

	// Register write-back
	output logic     wb_en,
	output reg_idx_t wb_addr,
	output word_t    wb_data
);

	logic [3:0]   opc;
	logic         is_nop, is_imm, is_incdec, is_dec;
	logic         is_alu_rr, is_alu_ri, is_branch;
	logic         uses_a, uses_b;
	branch_cond_t cond;
	logic         cond_branch, taken;
	logic         reg_hazard, flag_hazard, issue;

	reg_idx_t rd_a_addr, rd_b_addr;
	word_t    rd_a, rd_b;
	imm_hi_t  imm_hi;	// Prefix for the next instruction

	// Execute register, one instruction in flight
	logic     ex_valid;
	logic     ex_flags;	// In-flight instruction will write the flags
	reg_idx_t ex_dest;
	alu_op_t  ex_op;
	word_t    ex_a, ex_b;

	reg_idx_t nxt_dest;
	alu_op_t  nxt_op;
	word_t    nxt_a, nxt_b;

	word_t alu_result;
	logic  alu_z, alu_s, alu_c;
	logic  flag_z, flag_s, flag_c;

	function automatic logic cond_met(input branch_cond_t cnd, input logic fz, fs, fc);
		case (cnd)
			BZ:      return fz;
			BNZ:     return !fz;
			BS:      return fs;
			BNS:     return !fs;
			BC:      return fc;
			BNC:     return !fc;
			BA:      return 1'b1;
			default: return 1'b0;	// Branch link
		endcase
	endfunction

	// Decode of the head word
	assign opc       = head_word[15:12];
	assign is_nop    = (head_word == NOP_WORD);
	assign is_imm    = (opc == OPC_IMM);
	assign is_dec    = (head_word[15:8] == OPC_DEC_BYTE);
	assign is_incdec = (head_word[15:8] == OPC_INC_BYTE) || is_dec;
	assign is_alu_rr = (opc == OPC_ALU_RR);
	assign is_alu_ri = (opc == OPC_ALU_RI);
	assign is_branch = (opc == OPC_BRANCH);	// Bit 11 ignored as all branches are absolute

	assign rd_a_addr = head_word[7:4];	// ALU destination and first operand
	assign rd_b_addr = head_word[3:0];	// ALU source or inc/dec register
	assign uses_a    = is_alu_rr || is_alu_ri;
	assign uses_b    = is_alu_rr || is_incdec;

	assign cond        = branch_cond_t'(head_word[10:8]);
	assign cond_branch = is_branch && (cond != BA) && (cond != BL);
	assign taken       = cond_met(cond, flag_z, flag_s, flag_c);

	// Interlock against the one instruction in flight
	assign reg_hazard = ex_valid &&
		((uses_a && (ex_dest == rd_a_addr)) || (uses_b && (ex_dest == rd_b_addr)));
	assign flag_hazard = ex_flags && cond_branch;
	assign issue       = head_valid && !reg_hazard && !flag_hazard;

	assign pop         = issue;
	assign redirect    = issue && is_branch && taken;
	assign redirect_pc = {imm_hi, head_word[3:0]};

	// Operands for the execute register
	always_comb begin
		nxt_op   = alu_op_t'(head_word[11:8]);
		nxt_a    = rd_a;
		nxt_b    = rd_b;
		nxt_dest = head_word[7:4];
		if (is_alu_ri)
			nxt_b = {imm_hi, head_word[3:0]};
		if (is_incdec) begin
			nxt_op   = is_dec ? ALU_SUB : ALU_ADD;	// Same register in and out
			nxt_a    = rd_b;
			nxt_b    = 16'd1;
			nxt_dest = head_word[3:0];
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			ex_valid <= 1'b0;
			ex_flags <= 1'b0;
			imm_hi   <= '0;
			flag_z   <= 1'b0;
			flag_s   <= 1'b0;
			flag_c   <= 1'b0;
		end else begin
			ex_valid <= issue && (is_alu_rr || is_alu_ri || is_incdec);
			ex_flags <= issue && (is_alu_rr || is_alu_ri);	// Inc/dec leave flags alone
			if (issue && !is_nop)
				imm_hi <= is_imm ? head_word[11:0] : '0;	// Used once, then cleared
			if (ex_flags) begin
				flag_z <= alu_z;
				flag_s <= alu_s;
				flag_c <= alu_c;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (issue) begin
			ex_dest <= nxt_dest;
			ex_op   <= nxt_op;
			ex_a    <= nxt_a;
			ex_b    <= nxt_b;
		end
	end

	slurm_alu i_alu (
		.op     (ex_op),
		.a      (ex_a),
		.b      (ex_b),
		.result (alu_result),
		.z      (alu_z),
		.s      (alu_s),
		.c      (alu_c)
	);

	slurm_regfile i_regfile (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.rd_a_addr (rd_a_addr),
		.rd_b_addr (rd_b_addr),
		.wr_en     (ex_valid),
		.wr_addr   (ex_dest),
		.wr_data   (alu_result),
		.rd_a      (rd_a),
		.rd_b      (rd_b)
	);

	assign wb_en   = ex_valid;
	assign wb_addr = ex_dest;
	assign wb_data = alu_result;

	// A conditional branch only resolves on flags that are already written
	a_flags_settled: assert property (@(posedge CLK) disable iff (!RSTb)
		issue && (is_alu_rr || is_alu_ri) |=> !(issue && cond_branch))
		else $error("conditional branch issued on flags still being written");

endmodule

`default_nettype wire

//--- slurm_fetch.sv
/*
 * slurm16 fetch stage
 * Program counter and instruction memory requests, pushing each
 * accepted word into the instruction queue
 */
`timescale 1ns/1ns
`default_nettype none

module slurm_fetch import slurm_pkg::*; (
	input  wire   CLK,
	input  wire   RSTb,

	// Instruction memory
	output logic  mem_valid,
	output word_t mem_addr,
	input  wire   mem_ready,
	input  word_t mem_rdata,

	// Instruction queue
	input  wire   not_full,
	output logic  push,
	output word_t push_word,

	// Taken branch from execute
	input  wire   redirect,
	input  word_t redirect_pc
);

	word_t pc;
	logic  req_en;	// Set once the core is out of reset

	assign mem_valid = req_en && not_full;	// Only ask when the queue has room
	assign mem_addr  = pc;
	assign push      = mem_valid && mem_ready;
	assign push_word = mem_rdata;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc     <= RESET_PC;
			req_en <= 1'b0;
		end else begin
			req_en <= 1'b1;
			if (redirect)
				pc <= redirect_pc;	// Branch wins over the step
			else if (push)
				pc <= pc + 16'd1;
		end
	end

	// A waiting request keeps its address until a branch moves it
	a_addr_stable: assert property (@(posedge CLK) disable iff (!RSTb)
		mem_valid && !mem_ready && !redirect |=> $stable(mem_addr))
		else $error("fetch address changed while a request was waiting");

endmodule

`default_nettype wire

//--- slurm_insn_queue.sv
/*
 * Instruction queue
 * Small circular FIFO of instruction words between fetch and execute,
 * emptied by a taken branch
 */
`timescale 1ns/1ns
`default_nettype none

module slurm_insn_queue import slurm_pkg::*; #(
	parameter int DEPTH = QUEUE_DEPTH
) (
	input  wire   CLK,
	input  wire   RSTb,
	input  wire   push,
	input  word_t push_word,
	input  wire   pop,
	input  wire   flush,
	output logic  not_full,
	output logic  head_valid,
	output word_t head_word
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	word_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_step(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + PTR_W'(1);
	endfunction

	assign not_full   = (count != CNT_W'(DEPTH));
	assign head_valid = (count != '0);
	assign head_word  = mem[rd_ptr];

	assign do_push = push && not_full && !flush;	// Fetched word is stale on a flush
	assign do_pop  = pop && head_valid && !flush;

	always_ff @(posedge CLK) begin
		if (!RSTb || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_step(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_step(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + CNT_W'(1);
				2'b01:   count <= count - CNT_W'(1);
				default: ;	// Both or neither, level unchanged
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr] <= push_word;
	end

	// Fetch and execute must respect the queue's levels
	a_push_legal: assert property (@(posedge CLK) disable iff (!RSTb) push |-> not_full)
		else $error("push into a full instruction queue");
	a_pop_legal: assert property (@(posedge CLK) disable iff (!RSTb) pop |-> head_valid)
		else $error("pop from an empty instruction queue");

endmodule

`default_nettype wire

//--- slurm_pkg.sv
/*
 * slurm16 core package
 * Word, register index and immediate types, ALU and branch encodings,
 * opcode classes and core constants
 */
`default_nettype none

package slurm_pkg;

	typedef logic [15:0] word_t;	// Data, address and instruction word
	typedef logic [3:0]  reg_idx_t;	// Sixteen registers
	typedef logic [11:0] imm_hi_t;	// Upper immediate held by the prefix

	// ALU operation, taken from bits 11:8 of an ALU instruction
	typedef enum logic [3:0] {
		ALU_MOV = 4'd0,
		ALU_ADD = 4'd1,
		ALU_SUB = 4'd2,
		ALU_AND = 4'd3,
		ALU_OR  = 4'd4,
		ALU_XOR = 4'd5
	} alu_op_t;

	// Branch condition, taken from bits 10:8 of a branch
	typedef enum logic [2:0] {
		BZ  = 3'd0,	// Zero
		BNZ = 3'd1,	// Not zero
		BS  = 3'd2,	// Sign
		BNS = 3'd3,	// Not sign
		BC  = 3'd4,	// Carry
		BNC = 3'd5,	// Not carry
		BA  = 3'd6,	// Always
		BL  = 3'd7	// Branch link, never taken here
	} branch_cond_t;

	localparam word_t NOP_WORD = 16'h0000;
	localparam word_t RESET_PC = 16'h0000;

	localparam int NUM_REGS    = 16;
	localparam int QUEUE_DEPTH = 2;

	// Top nibble opcode classes
	localparam logic [3:0] OPC_IMM    = 4'h1;
	localparam logic [3:0] OPC_ALU_RR = 4'h2;
	localparam logic [3:0] OPC_ALU_RI = 4'h3;
	localparam logic [3:0] OPC_BRANCH = 4'h4;

	// Inc and dec live under top nibble 0, told apart by the upper byte
	localparam logic [7:0] OPC_INC_BYTE = 8'h02;
	localparam logic [7:0] OPC_DEC_BYTE = 8'h03;

endpackage

`default_nettype wire

//--- slurm_regfile.sv
/*
 * slurm16 register file
 * Sixteen words, two combinational reads, one synchronous write
 */
`timescale 1ns/1ns
`default_nettype none

module slurm_regfile import slurm_pkg::*; (
	input  wire      CLK,
	input  wire      RSTb,
	input  reg_idx_t rd_a_addr,
	input  reg_idx_t rd_b_addr,
	input  wire      wr_en,
	input  reg_idx_t wr_addr,
	input  word_t    wr_data,
	output word_t    rd_a,
	output word_t    rd_b
);

	word_t regs [NUM_REGS];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// No write bypass, the interlock holds readers back a cycle
	assign rd_a = regs[rd_a_addr];
	assign rd_b = regs[rd_b_addr];

endmodule

`default_nettype wire

//--- tb_slurm_core.sv
/*
 * Directed testbench for the slurm16 core
 * Memory model, instruction-set reference interpreter and write-back checks
 */
`timescale 1ns/1ns
`default_nettype none

module tb_slurm_core;
	import slurm_pkg::*;

	localparam int MAX_PROG  = 32;	// Longest program in words
	localparam int NUM_TESTS = 7;
	localparam int CYC_LIMIT = 200 * MAX_PROG * NUM_TESTS;

	logic     CLK, RSTb, mem_ready, mem_valid, wb_en, rand_ready;
	word_t    mem_addr, mem_rdata, wb_data;
	reg_idx_t wb_addr;
	word_t    mem [256];
	word_t    prog_q[$];
	reg_idx_t exp_addr[$], obs_addr[$];
	word_t    exp_data[$], obs_data[$];
	int       errors, tests_run, tests_failed, cycles, seed, rnd;

	slurm_core i_dut (
		.CLK (CLK), .RSTb (RSTb),
		.mem_valid (mem_valid), .mem_addr (mem_addr),
		.mem_ready (mem_ready), .mem_rdata (mem_rdata),
		.wb_en (wb_en), .wb_addr (wb_addr), .wb_data (wb_data)
	);

	assign mem_rdata = mem[mem_addr[7:0]];	// Answers in the same cycle

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		rnd = $random(seed);
		mem_ready <= rand_ready ? rnd[0] : 1'b1;
		if (RSTb && wb_en) begin
			obs_addr.push_back(wb_addr);
			obs_data.push_back(wb_data);
		end
		cycles++;
		if (cycles > CYC_LIMIT) begin
			$display("Run stopped after %0d cycles, the core never finished", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Instruction encoders
	function automatic word_t enc_ri(input logic [3:0] op, rd, v);
		return {OPC_ALU_RI, op, rd, v};
	endfunction
	function automatic word_t enc_rr(input logic [3:0] op, rd, rs);
		return {OPC_ALU_RR, op, rd, rs};
	endfunction
	function automatic word_t enc_br(input logic [2:0] cnd, input logic [3:0] t);
		return {OPC_BRANCH, 1'b0, cnd, 4'h0, t};
	endfunction

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_reg(input string what, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("ERR %0t: %s got r%0d expected r%0d", $time, what, got, exp);
			errors++;
		end
	endtask

	// Walks the program by the instruction rules up to a branch-always to itself
	task automatic interpret();
		word_t r [16];
		logic fz, fs, fc, tk;
		imm_hi_t ih;
		word_t w, a, b, res;
		logic [16:0] wide;
		int pc, steps;
		for (int i = 0; i < 16; i++)
			r[i] = '0;
		{fz, fs, fc} = 3'b000;
		ih = '0;
		pc = 0;
		exp_addr.delete();
		exp_data.delete();
		for (steps = 0; steps < 2000; steps++) begin
			w = mem[pc[7:0]];
			case (w[15:12])
				4'h0: begin
					if (w[15:8] == 8'h02 || w[15:8] == 8'h03) begin
						r[w[3:0]] = (w[8]) ? r[w[3:0]] - 16'd1 : r[w[3:0]] + 16'd1;
						exp_addr.push_back(w[3:0]);
						exp_data.push_back(r[w[3:0]]);
					end
					if (w != 16'h0000)
						ih = '0;
					pc++;
				end
				4'h1: begin
					ih = w[11:0];
					pc++;
				end
				4'h2, 4'h3: begin
					a = r[w[7:4]];
					b = (w[15:12] == 4'h2) ? r[w[3:0]] : {ih, w[3:0]};
					wide = {1'b0, b};
					case (w[11:8])
						4'd1: wide = {1'b0, a} + {1'b0, b};
						4'd2: wide = {1'b0, a} - {1'b0, b};
						4'd3: wide = {1'b0, a & b};
						4'd4: wide = {1'b0, a | b};
						4'd5: wide = {1'b0, a ^ b};
						default: ;
					endcase
					res = wide[15:0];
					fc = wide[16];
					fz = (res == 16'h0000);
					fs = res[15];
					r[w[7:4]] = res;
					exp_addr.push_back(w[7:4]);
					exp_data.push_back(res);
					ih = '0;
					pc++;
				end
				4'h4: begin
					case (w[10:8])
						3'd0: tk = fz;
						3'd1: tk = !fz;
						3'd2: tk = fs;
						3'd3: tk = !fs;
						3'd4: tk = fc;
						3'd5: tk = !fc;
						3'd6: tk = 1'b1;
						default: tk = 1'b0;
					endcase
					if (w[10:8] == 3'd6 && int'({ih, w[3:0]}) == pc)
						break;
					pc = tk ? int'({ih, w[3:0]}) : pc + 1;
					ih = '0;
				end
				default: begin
					ih = '0;
					pc++;
				end
			endcase
		end
	endtask

	// Holds reset for five cycles while the program is loaded
	task automatic reset_with_program();
		RSTb <= 1'b0;
		for (int i = 0; i < 256; i++)
			mem[i] = (i < prog_q.size()) ? prog_q[i] : NOP_WORD;
		for (int i = 0; i < 5; i++) begin
			@(posedge CLK);
			// The first edge still shows the state from before reset
			if (i > 0 && (wb_en !== 1'b0 || mem_valid !== 1'b0)) begin
				$display("Write-back or fetch request active during reset at %0t", $time);
				errors++;
			end
		end
		obs_addr.delete();
		obs_data.delete();
		RSTb <= 1'b1;
	endtask

	task automatic report(input string name, input int err_before);
		tests_run++;
		if (errors != err_before) begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - err_before);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	task automatic run_program(input string name, input logic rnd_ready);
		int err_before, waited;
		err_before = errors;
		rand_ready = rnd_ready;
		reset_with_program();
		interpret();
		waited = 0;
		while (obs_addr.size() < exp_addr.size() && waited < 200 * prog_q.size()) begin
			@(posedge CLK);
			waited++;
		end
		repeat (30) @(posedge CLK);	// Catch stray writes after the halt loop
		if (obs_addr.size() != exp_addr.size()) begin
			$display("%s: saw %0d write-backs where %0d were expected", name,
				obs_addr.size(), exp_addr.size());
			errors++;
		end
		for (int i = 0; i < obs_addr.size() && i < exp_addr.size(); i++) begin
			check_reg({name, " wb_addr"}, obs_addr[i], exp_addr[i]);
			check_word({name, " wb_data"}, obs_data[i], exp_data[i]);
		end
		report(name, err_before);
	endtask

	task automatic test_reset();
		int err_before, waited;
		err_before = errors;
		prog_q = '{enc_br(BA, 4'd0)};
		reset_with_program();
		waited = 0;
		@(posedge CLK);
		while (mem_valid !== 1'b1 && waited < 4) begin
			@(posedge CLK);
			waited++;
		end
		if (mem_valid !== 1'b1) begin
			$display("No fetch request appeared after reset");
			errors++;
		end
		check_word("first mem_addr", mem_addr, RESET_PC);
		repeat (10) begin
			@(posedge CLK);
			if (wb_en !== 1'b0) begin
				$display("Write-back seen from a program that writes nothing at %0t", $time);
				errors++;
			end
		end
		report("reset", err_before);
	endtask

	task automatic load_alu_program();
		prog_q = '{enc_ri(0, 1, 5), enc_ri(0, 2, 3), enc_rr(0, 3, 1), enc_rr(1, 3, 2),
			enc_rr(2, 3, 1), enc_ri(3, 3, 6), enc_ri(4, 4, 10), enc_rr(5, 4, 1),
			16'h0204, 16'h0302, 16'h0305, enc_rr(2, 6, 1), enc_br(BA, 4'd12)};
	endtask

	task automatic load_branch_program();
		prog_q = '{enc_ri(0, 1, 0), enc_br(BNZ, 15), enc_br(BZ, 4), enc_ri(0, 15, 15),
			enc_ri(2, 1, 1), enc_br(BNS, 15), enc_br(BS, 8), enc_ri(0, 15, 15),
			enc_br(BNC, 15), enc_br(BC, 11), enc_ri(0, 15, 15), enc_ri(1, 1, 2),
			16'h1001, enc_br(BNZ, 0), enc_ri(0, 15, 15), enc_br(BA, 15),
			enc_ri(5, 2, 0), 16'h1001, enc_br(BNC, 4), enc_ri(0, 15, 15),
			enc_br(BS, 15), enc_br(BC, 15), enc_ri(2, 2, 1), enc_br(BZ, 15),
			enc_br(BL, 15), enc_ri(3, 2, 0), 16'h1001, enc_br(BNS, 13),
			enc_ri(0, 15, 15), enc_br(BA, 15)};
	endtask

	initial begin
		RSTb <= 1'b0;
		mem_ready <= 1'b1;
		rand_ready = 1'b0;
		seed = 46;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycles = 0;
		for (int i = 0; i < 256; i++)
			mem[i] = NOP_WORD;
		test_reset();
		load_alu_program();
		run_program("alu operations", 1'b0);
		prog_q = '{16'h1123, enc_ri(0, 1, 4), enc_ri(0, 2, 7), 16'h1fff, enc_ri(1, 1, 15),
			enc_rr(1, 1, 2), enc_br(BA, 4'd6)};
		run_program("immediate prefix", 1'b0);
		prog_q = '{enc_ri(0, 1, 1), enc_rr(1, 1, 1), enc_rr(1, 1, 1), 16'h0201,
			enc_rr(0, 2, 1), enc_rr(2, 2, 1), 16'h0302, enc_rr(5, 1, 2), enc_br(BA, 4'd8)};
		run_program("dependent chains", 1'b0);
		load_branch_program();
		run_program("branches", 1'b0);
		load_alu_program();
		run_program("alu operations, random ready", 1'b1);
		load_branch_program();
		run_program("branches, random ready", 1'b1);
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
